// ==== verilog/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// pipeline side
`define DC_ADDR_W       32
`define DC_WORD_W       32

// set and line geometry, 64 sets of 64 bytes
`define DC_INDEX_W      6
`define DC_WORD_OFF_W   4     // 16 words per line
`define DC_BYTE_OFF_W   6
`define DC_TAG_W        20    // addr bits above index and offset

// line size in bits and bytes
`define DC_LINE_W       512
`define DC_LINE_BYTES   64

// associativity
`define DC_WAYS         2

`endif

// ==== verilog/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dc_pkg;

    // vectors with a meaning of their own
    typedef logic [`DC_ADDR_W-1:0]          addr_t;
    typedef logic [`DC_WORD_W-1:0]          word_t;
    typedef logic [`DC_LINE_W-1:0]          line_t;
    typedef logic [`DC_TAG_W-1:0]           tag_t;
    typedef logic [`DC_INDEX_W-1:0]         index_t;
    typedef logic [`DC_LINE_BYTES-1:0]      bstrb_t;   // one bit per byte of a line
    typedef logic [1:0]                     size_t;    // 0 byte, 1 half, 2 word
    typedef logic [$clog2(`DC_WAYS)-1:0]    way_t;

    // one load or store from the pipeline
    typedef struct packed {
        addr_t  addr;
        logic   wr;      // store when set
        size_t  size;
        logic   sext;    // sign-extend a load
        word_t  wdata;   // store data, right aligned
    } dc_req_t;

    // main controller
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL,
        RESP
    } dc_state_e;

endpackage

// ==== verilog/dcache_word_align.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_word_align (
    input  dc_pkg::dc_req_t     i_req,
    input  dc_pkg::line_t       i_hit_line,
    input  dc_pkg::line_t       i_refill_line,
    input  logic                i_from_refill,
    output dc_pkg::line_t       o_wdata,
    output dc_pkg::bstrb_t      o_bstrb,
    output dc_pkg::word_t       o_load_word
);
    import dc_pkg::*;

    logic [`DC_BYTE_OFF_W-1:0]  off;
    logic [`DC_WORD_OFF_W-1:0]  word_sel;
    logic [3:0]                 size_mask;
    bstrb_t                     st_mask;
    line_t                      st_line;
    line_t                      merged;
    line_t                      src;
    word_t                      word;
    logic [7:0]                 lb;
    logic [15:0]                lh;

    assign off      = i_req.addr[`DC_BYTE_OFF_W-1:0];
    assign word_sel = i_req.addr[2 +: `DC_WORD_OFF_W];

    always_comb begin
        case (i_req.size)
            2'd0:    size_mask = 4'b0001;
            2'd1:    size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    assign st_mask = bstrb_t'(size_mask) << off;
    assign st_line = line_t'(i_req.wdata) << {off, 3'b000};

    // store bytes over the fetched line
    always_comb begin
        for (int b = 0; b < `DC_LINE_BYTES; b++) begin
            merged[b*8 +: 8] = (i_req.wr && st_mask[b]) ? st_line[b*8 +: 8]
                                                        : i_refill_line[b*8 +: 8];
        end
    end

    assign o_wdata = i_from_refill ? merged : st_line;
    assign o_bstrb = i_from_refill ? '1 : st_mask;

    // load path
    assign src  = i_from_refill ? i_refill_line : i_hit_line;
    assign word = src[{word_sel, 5'b00000} +: `DC_WORD_W];
    assign lb   = word[{off[1:0], 3'b000} +: 8];
    assign lh   = word[{off[1], 4'b0000} +: 16];

    always_comb begin
        case (i_req.size)
            2'd0:    o_load_word = {{24{lb[7] & i_req.sext}}, lb};
            2'd1:    o_load_word = {{16{lh[15] & i_req.sext}}, lh};
            default: o_load_word = word;
        endcase
    end

    always_comb begin
        assert ((i_req.size == 2'd0) || (i_req.size == 2'd1 && !off[0]) ||
                (i_req.size == 2'd2 && off[1:0] == 2'b00))
            else $error("dcache: misaligned request at %h", i_req.addr);
    end

endmodule

// ==== verilog/dcache_data_array.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_data_array (
    input  logic                    clk,
    input  dc_pkg::index_t          i_rd_index,
    input  dc_pkg::index_t          i_wr_index,
    input  logic [`DC_WAYS-1:0]     i_we,
    input  dc_pkg::bstrb_t          i_bstrb,
    input  dc_pkg::line_t           i_wdata,
    output dc_pkg::line_t           o_line0,
    output dc_pkg::line_t           o_line1
);
    import dc_pkg::*;

    localparam int SETS = 1 << `DC_INDEX_W;

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        line_t mem [SETS];
        line_t rd_q;

        // byte lanes, a refill just sets every strobe
        always_ff @(posedge clk) begin
            for (int b = 0; b < `DC_LINE_BYTES; b++) begin
                if (i_we[w] && i_bstrb[b]) begin
                    mem[i_wr_index][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
            rd_q <= mem[i_rd_index];
        end
    end

    assign o_line0 = g_way[0].rd_q;
    assign o_line1 = g_way[1].rd_q;

    // hit and refill both target a single way
    a_one_way: assert property (@(posedge clk) !(&i_we));

endmodule

// ==== verilog/dcache_tag_array.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tag_array (
    input  logic                    clk,
    input  logic                    rstn,
    input  dc_pkg::index_t          i_rd_index,
    input  dc_pkg::tag_t            i_req_tag,
    input  dc_pkg::index_t          i_wr_index,
    input  logic [`DC_WAYS-1:0]     i_tag_we,
    input  logic [`DC_WAYS-1:0]     i_dirty_we,
    input  logic                    i_dirty_val,
    input  logic                    i_lru_we,
    input  dc_pkg::way_t            i_lru_way,
    output logic                    o_hit,
    output dc_pkg::way_t            o_hit_way,
    output dc_pkg::way_t            o_victim_way,
    output logic                    o_victim_valid,
    output logic                    o_victim_dirty,
    output dc_pkg::tag_t            o_victim_tag
);
    import dc_pkg::*;

    localparam int SETS = 1 << `DC_INDEX_W;

    tag_t                   tag_mem [`DC_WAYS][SETS];
    logic [SETS-1:0]        valid [`DC_WAYS];
    logic [SETS-1:0]        dirty [`DC_WAYS];
    logic [SETS-1:0]        lru;          // way touched last, per set
    tag_t                   tag_q [`DC_WAYS];
    logic [`DC_WAYS-1:0]    valid_q;
    logic [`DC_WAYS-1:0]    dirty_q;
    way_t                   lru_q;
    logic [`DC_WAYS-1:0]    hit;

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (i_tag_we[w]) begin
                tag_mem[w][i_wr_index] <= i_req_tag;
            end
            tag_q[w] <= tag_mem[w][i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            lru     <= '0;
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (i_tag_we[w]) begin
                    valid[w][i_wr_index] <= 1'b1;
                end
                if (i_dirty_we[w]) begin
                    dirty[w][i_wr_index] <= i_dirty_val;
                end
                valid_q[w] <= valid[w][i_rd_index];
                dirty_q[w] <= dirty[w][i_rd_index];
            end
            if (i_lru_we) begin
                lru[i_wr_index] <= i_lru_way;
            end
            lru_q <= lru[i_rd_index];
        end
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == i_req_tag);
        end
    end

    assign o_hit          = |hit;
    assign o_hit_way      = hit[1];
    assign o_victim_way   = ~lru_q;   // the way not used last
    assign o_victim_valid = valid_q[o_victim_way];
    assign o_victim_dirty = dirty_q[o_victim_way];
    assign o_victim_tag   = tag_q[o_victim_way];

    a_one_hit: assert property (@(posedge clk) disable iff (!rstn) !(&hit));

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    i_req_valid,
    input  dc_pkg::dc_req_t         i_req,
    output logic                    o_req_ready,
    output logic                    o_resp_valid,
    output dc_pkg::word_t           o_resp_data,
    input  logic                    i_resp_ready,
    output logic                    o_mem_rd_valid,
    output dc_pkg::addr_t           o_mem_rd_addr,
    input  logic                    i_mem_rd_ready,
    output logic                    o_mem_wr_valid,
    output dc_pkg::addr_t           o_mem_wr_addr,
    input  logic                    i_mem_wr_ready,
    input  logic                    i_hit,
    input  dc_pkg::way_t            i_hit_way,
    input  dc_pkg::way_t            i_victim_way,
    input  logic                    i_victim_valid,
    input  logic                    i_victim_dirty,
    input  dc_pkg::tag_t            i_victim_tag,
    input  dc_pkg::word_t           i_lookup_word,
    input  dc_pkg::word_t           i_refill_word,
    output dc_pkg::index_t          o_rd_index,
    output dc_pkg::dc_req_t         o_buf_req,
    output logic [`DC_WAYS-1:0]     o_tag_we,
    output logic [`DC_WAYS-1:0]     o_dirty_we,
    output logic                    o_dirty_val,
    output logic                    o_lru_we,
    output dc_pkg::way_t            o_lru_way,
    output logic [`DC_WAYS-1:0]     o_data_we,
    output logic                    o_data_from_refill
);
    import dc_pkg::*;

    dc_state_e  state_q;
    dc_state_e  state_d;
    dc_req_t    req_q;
    word_t      resp_q;
    index_t     buf_index;
    logic       take_req;
    logic       rd_fire;
    logic       wr_fire;
    logic       resp_fire;

    assign take_req  = i_req_valid && o_req_ready;
    assign rd_fire   = o_mem_rd_valid && i_mem_rd_ready;
    assign wr_fire   = o_mem_wr_valid && i_mem_wr_ready;
    assign resp_fire = o_resp_valid && i_resp_ready;
    assign buf_index = req_q.addr[`DC_BYTE_OFF_W +: `DC_INDEX_W];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
            req_q   <= '0;
        end else begin
            state_q <= state_d;
            if (take_req) begin
                req_q <= i_req;
            end
        end
    end

    // response word captured on the edge that ends the hit or the refill
    always_ff @(posedge clk) begin
        if (state_q == LOOKUP && i_hit) begin
            resp_q <= req_q.wr ? '0 : i_lookup_word;
        end else if (rd_fire) begin
            resp_q <= req_q.wr ? '0 : i_refill_word;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (take_req) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (i_hit) begin
                    state_d = RESP;
                end else if (i_victim_valid && i_victim_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL_REQ;
                end
            end
            WRITEBACK: begin
                if (wr_fire) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (rd_fire) begin
                    state_d = REFILL;
                end
            end
            REFILL:  state_d = RESP;   // tag, dirty and lru catch up here
            RESP: begin
                if (resp_fire) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // array write strobes
    always_comb begin
        o_tag_we    = '0;
        o_dirty_we  = '0;
        o_dirty_val = 1'b1;
        o_lru_we    = 1'b0;
        o_lru_way   = i_hit_way;
        o_data_we   = '0;
        case (state_q)
            LOOKUP: begin
                if (i_hit) begin
                    o_lru_we = 1'b1;
                    if (req_q.wr) begin
                        o_data_we[i_hit_way]  = 1'b1;
                        o_dirty_we[i_hit_way] = 1'b1;
                    end
                end
            end
            REFILL_REQ: begin
                if (i_mem_rd_ready) begin
                    o_data_we[i_victim_way] = 1'b1;   // merged line straight from memory
                end
            end
            REFILL: begin
                o_tag_we[i_victim_way]   = 1'b1;
                o_dirty_we[i_victim_way] = 1'b1;
                o_dirty_val              = req_q.wr;
                o_lru_we                 = 1'b1;
                o_lru_way                = i_victim_way;
            end
            default: ;
        endcase
    end

    assign o_req_ready        = (state_q == IDLE);
    assign o_resp_valid       = (state_q == RESP);
    assign o_resp_data        = resp_q;
    assign o_mem_rd_valid     = (state_q == REFILL_REQ);
    assign o_mem_rd_addr      = {req_q.addr[`DC_ADDR_W-1:`DC_BYTE_OFF_W], {`DC_BYTE_OFF_W{1'b0}}};
    assign o_mem_wr_valid     = (state_q == WRITEBACK);
    assign o_mem_wr_addr      = {i_victim_tag, buf_index, {`DC_BYTE_OFF_W{1'b0}}};
    assign o_data_from_refill = (state_q == REFILL_REQ);
    assign o_buf_req          = req_q;
    // arrays follow the incoming request in idle, then stay on the buffered set
    assign o_rd_index = (state_q == IDLE && i_req_valid) ?
                        i_req.addr[`DC_BYTE_OFF_W +: `DC_INDEX_W] : buf_index;

    a_rd_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rd_valid && !i_mem_rd_ready |=> o_mem_rd_valid && $stable(o_mem_rd_addr));
    a_wr_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_wr_valid && !i_mem_wr_ready |=> o_mem_wr_valid && $stable(o_mem_wr_addr));
    // a waiting request stays put until taken
    a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_req_valid && !o_req_ready |=> !i_req_valid || $stable(i_req));

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top (
    input  logic                clk,
    input  logic                rstn,
    // pipeline request
    input  logic                i_req_valid,
    input  dc_pkg::dc_req_t     i_req,
    output logic                o_req_ready,
    // pipeline response
    output logic                o_resp_valid,
    output dc_pkg::word_t       o_resp_data,
    input  logic                i_resp_ready,
    // memory line read
    output logic                o_mem_rd_valid,
    output dc_pkg::addr_t       o_mem_rd_addr,
    input  logic                i_mem_rd_ready,
    input  dc_pkg::line_t       i_mem_rd_data,
    // memory line write
    output logic                o_mem_wr_valid,
    output dc_pkg::addr_t       o_mem_wr_addr,
    output dc_pkg::line_t       o_mem_wr_data,
    input  logic                i_mem_wr_ready
);
    import dc_pkg::*;

    dc_req_t                buf_req;
    index_t                 rd_index;
    index_t                 buf_index;
    tag_t                   buf_tag;
    logic                   hit;
    way_t                   hit_way;
    way_t                   victim_way;
    logic                   victim_valid;
    logic                   victim_dirty;
    tag_t                   victim_tag;
    logic [`DC_WAYS-1:0]    tag_we;
    logic [`DC_WAYS-1:0]    dirty_we;
    logic [`DC_WAYS-1:0]    data_we;
    logic                   dirty_val;
    logic                   lru_we;
    way_t                   lru_way;
    logic                   data_from_refill;
    line_t                  line0;
    line_t                  line1;
    line_t                  hit_line;
    line_t                  wdata;
    bstrb_t                 bstrb;
    word_t                  load_word;

    assign buf_index = buf_req.addr[`DC_BYTE_OFF_W +: `DC_INDEX_W];
    assign buf_tag   = buf_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];

    assign hit_line      = hit_way ? line1 : line0;
    assign o_mem_wr_data = victim_way ? line1 : line0;   // held while in writeback

    dcache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn),
        .i_req_valid(i_req_valid), .i_req(i_req), .o_req_ready(o_req_ready),
        .o_resp_valid(o_resp_valid), .o_resp_data(o_resp_data), .i_resp_ready(i_resp_ready),
        .o_mem_rd_valid(o_mem_rd_valid), .o_mem_rd_addr(o_mem_rd_addr),
        .i_mem_rd_ready(i_mem_rd_ready),
        .o_mem_wr_valid(o_mem_wr_valid), .o_mem_wr_addr(o_mem_wr_addr),
        .i_mem_wr_ready(i_mem_wr_ready),
        .i_hit(hit), .i_hit_way(hit_way), .i_victim_way(victim_way),
        .i_victim_valid(victim_valid), .i_victim_dirty(victim_dirty),
        .i_victim_tag(victim_tag),
        .i_lookup_word(load_word), .i_refill_word(load_word),   // one extractor, two phases
        .o_rd_index(rd_index), .o_buf_req(buf_req),
        .o_tag_we(tag_we), .o_dirty_we(dirty_we), .o_dirty_val(dirty_val),
        .o_lru_we(lru_we), .o_lru_way(lru_way),
        .o_data_we(data_we), .o_data_from_refill(data_from_refill)
    );

    dcache_tag_array u_tag (
        .clk(clk), .rstn(rstn),
        .i_rd_index(rd_index), .i_req_tag(buf_tag), .i_wr_index(buf_index),
        .i_tag_we(tag_we), .i_dirty_we(dirty_we), .i_dirty_val(dirty_val),
        .i_lru_we(lru_we), .i_lru_way(lru_way),
        .o_hit(hit), .o_hit_way(hit_way), .o_victim_way(victim_way),
        .o_victim_valid(victim_valid), .o_victim_dirty(victim_dirty),
        .o_victim_tag(victim_tag)
    );

    dcache_data_array u_data (
        .clk(clk), .i_rd_index(rd_index), .i_wr_index(buf_index),
        .i_we(data_we), .i_bstrb(bstrb), .i_wdata(wdata),
        .o_line0(line0), .o_line1(line1)
    );

    dcache_word_align u_align (
        .i_req(buf_req), .i_hit_line(hit_line), .i_refill_line(i_mem_rd_data),
        .i_from_refill(data_from_refill),
        .o_wdata(wdata), .o_bstrb(bstrb), .o_load_word(load_word)
    );

endmodule

// ==== verif/tb_mem_model.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_mem_model (
    input  logic            clk,
    input  logic            rstn,
    input  logic            i_rd_valid,
    input  dc_pkg::addr_t   i_rd_addr,
    output logic            o_rd_ready,
    output dc_pkg::line_t   o_rd_data,
    input  logic            i_wr_valid,
    input  dc_pkg::addr_t   i_wr_addr,
    input  dc_pkg::line_t   i_wr_data,
    output logic            o_wr_ready
);
    import dc_pkg::*;

    line_t  mem [addr_t];          // written lines, keyed by line address
    int     wr_count [addr_t];
    int     rd_count = 0;
    addr_t  last_rd_addr = '0;
    addr_t  last_wr_addr = '0;
    line_t  last_wr_data = '0;
    logic   rd_ready = 1'b0;
    logic   wr_ready = 1'b0;
    line_t  rd_data = '0;
    int     rd_wait = 0;
    int     wr_wait = 0;

    assign o_rd_ready = rd_ready;
    assign o_wr_ready = wr_ready;
    assign o_rd_data  = rd_data;

    // contents of a byte never written, spread over the whole address
    function automatic logic [7:0] init_byte(addr_t a);
        logic [31:0] h;
        h = a * 32'h9e3779b1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic line_t read_line(addr_t a);
        line_t l;
        for (int b = 0; b < `DC_LINE_BYTES; b++) begin
            l[b*8 +: 8] = init_byte(a + addr_t'(b));
        end
        if (mem.exists(a)) begin
            l = mem[a];
        end
        return l;
    endfunction

    // transfers happen on the rising edge
    always @(posedge clk) begin
        if (i_rd_valid && rd_ready) begin
            rd_count++;
            last_rd_addr = i_rd_addr;
        end
        if (i_wr_valid && wr_ready) begin
            mem[i_wr_addr] = i_wr_data;
            if (wr_count.exists(i_wr_addr)) begin
                wr_count[i_wr_addr]++;
            end else begin
                wr_count[i_wr_addr] = 1;
            end
            last_wr_addr = i_wr_addr;
            last_wr_data = i_wr_data;
        end
    end

    // ready pulses after a random wait of 0 to 3 cycles
    always @(negedge clk) begin
        if (!rstn) begin
            rd_ready = 1'b0;
            wr_ready = 1'b0;
        end else begin
            if (rd_ready) begin
                rd_ready = 1'b0;   // valid was high, so the line went across
                rd_wait  = $urandom_range(3, 0);
            end else if (i_rd_valid) begin
                if (rd_wait == 0) begin
                    rd_ready = 1'b1;
                    rd_data  = read_line(i_rd_addr);
                end else begin
                    rd_wait--;
                end
            end
            if (wr_ready) begin
                wr_ready = 1'b0;
                wr_wait  = $urandom_range(3, 0);
            end else if (i_wr_valid) begin
                if (wr_wait == 0) begin
                    wr_ready = 1'b1;
                end else begin
                    wr_wait--;
                end
            end
        end
    end

endmodule

// ==== verif/tb_dcache.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_dcache;
    import dc_pkg::*;

    localparam int CLK_NS     = 4;
    localparam int N_RAND     = 400;
    localparam int N_DIRECTED = 72;
    localparam int N_OPS      = N_DIRECTED + N_RAND;

    logic       clk = 1'b0;
    logic       rstn = 1'b0;
    logic       req_valid = 1'b0;
    dc_req_t    req = '0;
    logic       req_ready;
    logic       resp_valid;
    word_t      resp_data;
    logic       resp_ready = 1'b1;
    logic       mem_rd_valid;
    addr_t      mem_rd_addr;
    logic       mem_rd_ready;
    line_t      mem_rd_data;
    logic       mem_wr_valid;
    addr_t      mem_wr_addr;
    line_t      mem_wr_data;
    logic       mem_wr_ready;

    logic [7:0] shadow [addr_t];   // every byte stored so far
    word_t      exp_q [$];
    int         n_issued = 0;
    int         n_resp = 0;
    int         resp_errs = 0;
    int         stray_resps = 0;
    int         check_errs = 0;
    logic       bp_on = 1'b0;

    always #(CLK_NS/2) clk = ~clk;

    dcache_top dut (
        .clk(clk), .rstn(rstn),
        .i_req_valid(req_valid), .i_req(req), .o_req_ready(req_ready),
        .o_resp_valid(resp_valid), .o_resp_data(resp_data), .i_resp_ready(resp_ready),
        .o_mem_rd_valid(mem_rd_valid), .o_mem_rd_addr(mem_rd_addr),
        .i_mem_rd_ready(mem_rd_ready), .i_mem_rd_data(mem_rd_data),
        .o_mem_wr_valid(mem_wr_valid), .o_mem_wr_addr(mem_wr_addr),
        .o_mem_wr_data(mem_wr_data), .i_mem_wr_ready(mem_wr_ready)
    );

    tb_mem_model u_mem (
        .clk(clk), .rstn(rstn),
        .i_rd_valid(mem_rd_valid), .i_rd_addr(mem_rd_addr),
        .o_rd_ready(mem_rd_ready), .o_rd_data(mem_rd_data),
        .i_wr_valid(mem_wr_valid), .i_wr_addr(mem_wr_addr),
        .i_wr_data(mem_wr_data), .o_wr_ready(mem_wr_ready)
    );

    // same spread as the backing memory
    function automatic logic [7:0] init_byte(addr_t a);
        logic [31:0] h;
        h = a * 32'h9e3779b1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic logic [7:0] shadow_byte(addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_byte(a);
    endfunction

    // little-endian load with sign or zero extension
    function automatic word_t ref_load(addr_t a, size_t sz, logic sx);
        word_t w;
        w = {shadow_byte(a + 3), shadow_byte(a + 2), shadow_byte(a + 1), shadow_byte(a)};
        case (sz)
            2'd0:    return {{24{sx & w[7]}}, w[7:0]};
            2'd1:    return {{16{sx & w[15]}}, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic store_shadow(addr_t a, size_t sz, word_t d);
        int n;
        n = (sz == 2'd0) ? 1 : (sz == 2'd1) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            shadow[a + addr_t'(i)] = d[i*8 +: 8];
        end
    endtask

    task automatic mismatch_error(string sig, word_t got, word_t exp);
        check_errs++;
        $display("** Error: %s = %h, expected %h", sig, got, exp);
    endtask

    task automatic protocol_error(string msg);
        check_errs++;
        $display("%s at %0t ns", msg, $time);
    endtask

    // one request, then wait for its response
    task automatic access(addr_t a, logic wr, size_t sz, logic sx, word_t wd);
        dc_req_t r;
        r.addr  = a;
        r.wr    = wr;
        r.size  = sz;
        r.sext  = sx;
        r.wdata = wd;
        exp_q.push_back(wr ? word_t'(0) : ref_load(a, sz, sx));
        if (wr) begin
            store_shadow(a, sz, wd);
        end
        n_issued++;
        @(negedge clk);
        req       = r;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(negedge clk);   // taken on the edge just passed
        req_valid = 1'b0;
        while (n_resp < n_issued) begin
            @(negedge clk);
        end
    endtask

    task automatic check_reset_state();
        assert (req_ready === 1'b1)
            else mismatch_error("o_req_ready", word_t'(req_ready), 1);
        assert (resp_valid === 1'b0)
            else mismatch_error("o_resp_valid", word_t'(resp_valid), 0);
        assert (mem_rd_valid === 1'b0)
            else mismatch_error("o_mem_rd_valid", word_t'(mem_rd_valid), 0);
        assert (mem_wr_valid === 1'b0)
            else mismatch_error("o_mem_wr_valid", word_t'(mem_wr_valid), 0);
    endtask

    task automatic cold_line_test();
        int reads;
        reads = u_mem.rd_count;
        access(32'h0000_0104, 1'b0, 2'd2, 1'b0, '0);
        assert (u_mem.rd_count == reads + 1) else protocol_error("cold load did not read one line");
        assert (u_mem.last_rd_addr == 32'h0000_0100)
            else mismatch_error("o_mem_rd_addr", u_mem.last_rd_addr, 32'h0000_0100);
        reads = u_mem.rd_count;
        access(32'h0000_0104, 1'b0, 2'd2, 1'b0, '0);
        assert (u_mem.rd_count == reads) else protocol_error("repeated load went to memory");
    endtask

    task automatic sub_word_test();
        addr_t base;
        base = 32'h0000_0200;
        for (int i = 0; i < 8; i++) begin
            access(base + addr_t'(i), 1'b1, 2'd0, 1'b0, $urandom);
        end
        for (int i = 8; i < 16; i += 2) begin
            access(base + addr_t'(i), 1'b1, 2'd1, 1'b0, $urandom);
        end
        for (int i = 0; i < 16; i++) begin
            access(base + addr_t'(i), 1'b0, 2'd0, 1'b0, '0);
            access(base + addr_t'(i), 1'b0, 2'd0, 1'b1, '0);
            if (i % 2 == 0) begin
                access(base + addr_t'(i), 1'b0, 2'd1, 1'b0, '0);
                access(base + addr_t'(i), 1'b0, 2'd1, 1'b1, '0);
            end
            if (i % 4 == 0) begin
                access(base + addr_t'(i), 1'b0, 2'd2, 1'b0, '0);
            end
        end
    endtask

    // A, B and C share set 12
    task automatic lru_evict_test();
        addr_t a_line;
        addr_t b_line;
        addr_t c_line;
        line_t exp_line;
        int    reads;
        a_line = 32'h0000_0300;
        b_line = 32'h0000_1300;
        c_line = 32'h0000_2300;
        access(a_line, 1'b0, 2'd2, 1'b0, '0);
        access(b_line + 8, 1'b1, 2'd2, 1'b0, $urandom);
        access(a_line, 1'b0, 2'd2, 1'b0, '0);
        access(c_line + 4, 1'b0, 2'd2, 1'b0, '0);   // B is least recent and dirty
        for (int b = 0; b < `DC_LINE_BYTES; b++) begin
            exp_line[b*8 +: 8] = shadow_byte(b_line + addr_t'(b));
        end
        assert (u_mem.wr_count[b_line] == 1) else protocol_error("line B not written back once");
        assert (u_mem.last_wr_addr == b_line)
            else mismatch_error("o_mem_wr_addr", u_mem.last_wr_addr, b_line);
        assert (u_mem.last_wr_data == exp_line) else begin
            check_errs++;
            $display("** Error: o_mem_wr_data = %h, expected %h", u_mem.last_wr_data, exp_line);
        end
        reads = u_mem.rd_count;
        access(a_line, 1'b0, 2'd2, 1'b0, '0);
        assert (u_mem.rd_count == reads) else protocol_error("reload of line A read memory");
        access(b_line + 8, 1'b0, 2'd2, 1'b0, '0);
    endtask

    task automatic random_test();
        addr_t a;
        size_t sz;
        logic  wr;
        logic  sx;
        bp_on = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            sz = size_t'($urandom_range(2, 0));
            a  = addr_t'($urandom_range(32'h3fff, 0));
            if (sz == 2'd1) begin
                a[0] = 1'b0;
            end else if (sz == 2'd2) begin
                a[1:0] = 2'b00;
            end
            wr = $urandom_range(1, 0) == 1;
            sx = $urandom_range(1, 0) == 1;
            access(a, wr, sz, sx, $urandom);
        end
        bp_on = 1'b0;
    endtask

    task automatic close_run();
        $display("errors: %0d response mismatches, %0d stray responses, %0d check failures",
                 resp_errs, stray_resps, check_errs);
        if (resp_errs == 0 && stray_resps == 0 && check_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        resp_ready = bp_on ? ($urandom_range(3, 0) != 0) : 1'b1;
    end

    // responses come back in request order
    always @(posedge clk) begin : compare
        word_t exp;
        if (rstn && resp_valid && resp_ready) begin
            assert (exp_q.size() != 0) else begin
                stray_resps++;
                $display("response with no request outstanding at %0t ns", $time);
            end
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                assert (resp_data === exp) else begin
                    resp_errs++;
                    $display("** Error: o_resp_data = %h, expected %h (response %0d)",
                             resp_data, exp, n_resp);
                end
            end
            n_resp++;
        end
    end

    initial begin
        void'($urandom(59));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_reset_state();
        cold_line_test();
        sub_word_test();
        lru_evict_test();
        random_test();
        repeat (4) @(negedge clk);
        assert (exp_q.size() == 0) else protocol_error("responses missing at end of run");
        close_run();
    end

    initial begin : watchdog
        #(N_OPS * 200 * CLK_NS);
        protocol_error("watchdog expired, the DUT stopped answering");
        close_run();
    end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_word_align.sv
verilog/dcache_data_array.sv
verilog/dcache_tag_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verif/tb_mem_model.sv
verif/tb_dcache.sv

// ==== Makefile ====
TOP = tb_dcache

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean
